// File: filelist.f
uf_pkg.sv
link_ctx_mem.sv
neighbor_link.sv
vertex_unit.sv
stage_ctrl.sv
result_collect.sv
uf_chain_top.sv
uf_chain_chk.sv
tb_uf_chain.sv

// File: link_ctx_mem.sv
module link_ctx_mem (
    input  logic clk,
    input  logic we,
    input  logic [uf_pkg::CTX_ADDR_WIDTH-1:0] addr,
    input  logic [uf_pkg::CTX_WIDTH-1:0] di,
    output logic [uf_pkg::CTX_WIDTH-1:0] dout
);
    import uf_pkg::*;

    logic [CTX_WIDTH-1:0] mem [NUM_CONTEXTS] = '{default: '0};  // unused contexts start empty

    // old word comes out on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= di;
        end
        dout <= mem[addr];
    end

endmodule

// File: neighbor_link.sv
module neighbor_link (
    input  logic clk,
    input  logic reset,
    input  uf_pkg::stage_t global_stage,
    input  logic link_load,
    input  logic [uf_pkg::WEIGHT_WIDTH-1:0] weight_in,
    input  uf_pkg::bc_t bc_in,
    input  logic reset_edge,
    input  logic do_not_store,
    input  logic a_increase,
    input  logic b_increase,
    input  uf_pkg::vertex_data_t a_input_data,
    input  uf_pkg::vertex_data_t b_input_data,
    output uf_pkg::vertex_data_t a_output_data,
    output uf_pkg::vertex_data_t b_output_data,
    output logic fully_grown,
    output logic is_boundary,
    output logic is_error
);
    import uf_pkg::*;

    stage_t stage;  // global stage seen one cycle late
    logic [WEIGHT_WIDTH-1:0] weight;
    bc_t bc;
    logic [WEIGHT_WIDTH-1:0] growth;
    logic [WEIGHT_WIDTH:0] growth_sum;
    logic [WEIGHT_WIDTH-1:0] growth_new;
    logic internal;
    logic swap;
    logic [CTX_ADDR_WIDTH-1:0] rd_addr;
    logic [CTX_ADDR_WIDTH-1:0] wr_addr;
    logic [CTX_ADDR_WIDTH-1:0] mem_addr;
    logic [CTX_WIDTH-1:0] mem_dout;
    logic [WEIGHT_WIDTH-1:0] growth_mem;
    logic is_error_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            weight <= WEIGHT_WIDTH'(MAX_WEIGHT);
            bc <= BC_NONE;
        end else begin
            stage <= global_stage;
            if (link_load) begin
                weight <= weight_in;
                bc <= bc_in;
            end
        end
    end

    assign internal = (bc != BC_BOUNDARY) && (bc != BC_ABSENT);

    always_comb begin
        case (bc)
            BC_BOUNDARY: growth_sum = growth + a_increase;  // only the chain side pushes
            BC_ABSENT: growth_sum = '0;
            default: growth_sum = growth + a_increase + b_increase;
        endcase
    end

    assign growth_new = (growth_sum > weight) ? weight : growth_sum[WEIGHT_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset || reset_edge) begin
            growth <= '0;
            is_error <= 1'b0;
        end else if (swap) begin
            growth <= growth_mem;
            is_error <= is_error_mem && (bc != BC_ABSENT);
        end else if (stage == STAGE_GROW) begin
            growth <= growth_new;
        end else if (stage == STAGE_RESULT_VALID) begin
            is_error <= fully_grown && (bc != BC_ABSENT);
        end
    end

    assign fully_grown = (growth >= weight);
    assign is_boundary = (bc == BC_BOUNDARY) && fully_grown;

    // a grown internal edge joins its two vertices
    assign a_output_data = (internal && fully_grown) ? b_input_data : '0;
    assign b_output_data = (internal && fully_grown) ? a_input_data : '0;

    assign swap = (stage == STAGE_WRITE_TO_MEM) && !do_not_store;
    assign mem_addr = swap ? wr_addr : rd_addr;
    assign {growth_mem, is_error_mem} = mem_dout;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr <= '0;
            rd_addr <= CTX_ADDR_WIDTH'(1);  // next context to bring in
        end else if (swap) begin
            wr_addr <= (wr_addr == NUM_CONTEXTS - 1) ? '0 : wr_addr + 1'b1;
            rd_addr <= (rd_addr == NUM_CONTEXTS - 1) ? '0 : rd_addr + 1'b1;
        end
    end

    link_ctx_mem i_ctx_mem (
        .clk(clk),
        .we(swap),
        .addr(mem_addr),
        .di({growth, is_error}),
        .dout(mem_dout)
    );

endmodule

// File: result_collect.sv
module result_collect (
    input  logic clk,
    input  logic reset,
    input  uf_pkg::stage_t global_stage,
    input  logic run_start,
    input  logic [uf_pkg::NUM_LINKS-1:0] link_error,
    output logic [uf_pkg::NUM_LINKS-1:0] correction,
    output logic busy,
    output logic done
);
    import uf_pkg::*;

    // links see the result stage a cycle late and need one more for is_error
    logic [1:0] result_dly;

    always_ff @(posedge clk) begin
        if (reset) begin
            correction <= '0;
            result_dly <= '0;
            done <= 1'b0;
        end else begin
            correction <= link_error;  // follows context swaps as well
            result_dly <= {result_dly[0], global_stage == STAGE_RESULT_VALID};
            done <= result_dly[1];     // lines up with the new correction
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (run_start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;  // low again the cycle after done
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uf_chain testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_uf_chain -f filelist.f -o sim_uf_chain \
    && ./obj_dir/sim_uf_chain > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: stage_ctrl.sv
module stage_ctrl (
    input  logic clk,
    input  logic reset,
    input  uf_pkg::cmd_word_u cmd,
    input  logic cmd_valid,
    input  logic [uf_pkg::NUM_VERTICES-1:0] grow_req,
    output uf_pkg::stage_t global_stage,
    output logic [uf_pkg::NUM_LINKS-1:0] link_load,
    output logic [uf_pkg::WEIGHT_WIDTH-1:0] load_weight,
    output uf_pkg::bc_t load_bc,
    output logic syndrome_load,
    output logic [uf_pkg::NUM_VERTICES-1:0] defect_mask,
    output logic run_start
);
    import uf_pkg::*;

    logic [ROUND_WIDTH-1:0] round_cnt;
    logic [MERGE_CNT_WIDTH-1:0] merge_cnt;
    logic accept;

    assign accept = cmd_valid && (global_stage == STAGE_IDLE);  // busy stages drop commands
    assign run_start = accept && (cmd.cfg.kind == CMD_RUN);

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage <= STAGE_IDLE;
            round_cnt <= '0;
            merge_cnt <= '0;
            link_load <= '0;
            syndrome_load <= 1'b0;
        end else begin
            link_load <= '0;
            syndrome_load <= 1'b0;
            case (global_stage)
                STAGE_IDLE: begin
                    if (accept) begin
                        case (cmd.cfg.kind)
                            CMD_LOAD_LINK: begin
                                global_stage <= STAGE_LOAD;
                                if (cmd.cfg.link < NUM_LINKS) begin
                                    link_load[cmd.cfg.link] <= 1'b1;
                                end
                            end
                            CMD_SYNDROME: begin
                                global_stage <= STAGE_LOAD;
                                syndrome_load <= 1'b1;
                            end
                            CMD_RUN: begin
                                global_stage <= STAGE_GROW;
                                round_cnt <= '0;
                            end
                            default: global_stage <= STAGE_WRITE_TO_MEM;  // store
                        endcase
                    end
                end
                STAGE_GROW: begin
                    global_stage <= STAGE_MERGE;
                    merge_cnt <= '0;
                    round_cnt <= round_cnt + 1'b1;
                end
                STAGE_MERGE: begin
                    if (merge_cnt == MERGE_CYCLES - 1) begin
                        // stop once every cluster is quiet, or at the round cap
                        if (!(|grow_req) || (round_cnt == MAX_ROUNDS)) begin
                            global_stage <= STAGE_RESULT_VALID;
                        end else begin
                            global_stage <= STAGE_GROW;
                        end
                    end else begin
                        merge_cnt <= merge_cnt + 1'b1;
                    end
                end
                default: global_stage <= STAGE_IDLE;  // load, store and result last one cycle
            endcase
        end
    end

    // payload that goes with the strobes
    always_ff @(posedge clk) begin
        if (accept) begin
            if (cmd.cfg.weight > MAX_WEIGHT) begin
                load_weight <= WEIGHT_WIDTH'(MAX_WEIGHT);
            end else begin
                load_weight <= cmd.cfg.weight;
            end
            load_bc <= cmd.cfg.bc;
            defect_mask <= cmd.syn.defect;
        end
    end

endmodule

// File: tb_uf_chain.sv
module tb_uf_chain;
    import uf_pkg::*;

    localparam int NUM_RANDOM = 8;
    localparam int NUM_TESTS = 5 + NUM_RANDOM;
    localparam int RUN_BUDGET = MAX_ROUNDS * (MERGE_CYCLES + 1) + 20;
    localparam int TEST_BUDGET = 2 * RUN_BUDGET + 14 * 8;  // two runs and the loads around them
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_BUDGET;

    logic clk;
    logic reset;
    cmd_word_u cmd;
    logic cmd_valid;
    logic do_not_store;
    logic [NUM_LINKS-1:0] correction;
    logic busy;
    logic done;

    int errors = 0;
    int failed_tests = 0;
    int test_count = 0;
    int errors_at_start;
    string test_name;
    int cycles;
    logic [15:0] lfsr = 16'd29973;

    // link setup as loaded, mirrored for the reference model
    int link_w [NUM_LINKS];
    int link_bc [NUM_LINKS];
    // reference model state
    int m_root [NUM_VERTICES];
    bit m_def [NUM_VERTICES];
    bit m_tb [NUM_VERTICES];
    bit m_match [NUM_VERTICES];
    int m_growth [NUM_LINKS];
    int next_growth [NUM_LINKS];

    uf_chain_top i_uf_chain_top (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .do_not_store(do_not_store),
        .correction(correction),
        .busy(busy),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a run never finished", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic bit link_grown(input int j);
        return m_growth[j] >= link_w[j];
    endfunction

    function automatic bit link_joins(input int j);
        return link_bc[j] != int'(BC_BOUNDARY) && link_bc[j] != int'(BC_ABSENT) && link_grown(j);
    endfunction

    function automatic bit boundary_hit(input int j);
        return link_bc[j] == int'(BC_BOUNDARY) && link_grown(j);
    endfunction

    function automatic bit wants_growth(input int i);
        return m_def[i] && !m_match[i] && !m_tb[i];
    endfunction

    function automatic bit any_request();
        for (int i = 0; i < NUM_VERTICES; i++) begin
            if (wants_growth(i)) return 1'b1;
        end
        return 1'b0;
    endfunction

    // growth per link from the requests of the vertices it touches
    task automatic plan_growth();
        int a;
        int b;
        int g;
        for (int j = 0; j < NUM_LINKS; j++) begin
            a = int'(wants_growth((j == 0) ? 0 : j - 1));
            b = (j > 0 && j < NUM_LINKS - 1) ? int'(wants_growth(j)) : 0;
            if (link_bc[j] == int'(BC_ABSENT)) g = 0;
            else if (link_bc[j] == int'(BC_BOUNDARY)) g = m_growth[j] + a;
            else g = m_growth[j] + a + b;
            next_growth[j] = (g > link_w[j]) ? link_w[j] : g;
        end
    endtask

    // one merge cycle, every vertex looks at the old state of its neighbours
    task automatic merge_step();
        int root_n [NUM_VERTICES];
        bit def_n [NUM_VERTICES];
        bit tb_n [NUM_VERTICES];
        bit match_n [NUM_VERTICES];
        int nb;
        bit linked;
        for (int i = 0; i < NUM_VERTICES; i++) begin
            root_n[i] = m_root[i];
            def_n[i] = m_def[i];
            match_n[i] = m_match[i];
            tb_n[i] = m_tb[i] | boundary_hit(i) | boundary_hit(i + 1);
            for (int side = 0; side < 2; side++) begin
                nb = (side == 0) ? i - 1 : i + 1;
                linked = (side == 0) ? (i > 0 && link_joins(i))
                                     : (i < NUM_VERTICES - 1 && link_joins(i + 1));
                if (linked) begin
                    tb_n[i] = tb_n[i] | m_tb[nb];
                    if (m_def[nb]) begin
                        if (m_match[nb] || (m_def[i] && m_root[nb] != m_root[i])) begin
                            match_n[i] = 1'b1;
                        end
                        if (!def_n[i] || m_root[nb] < root_n[i]) root_n[i] = m_root[nb];
                        def_n[i] = 1'b1;  // cluster now holds a defect
                    end
                end
            end
        end
        m_root = root_n;
        m_def = def_n;
        m_tb = tb_n;
        m_match = match_n;
    endtask

    task automatic predict(input logic [NUM_VERTICES-1:0] mask,
                           output logic [NUM_LINKS-1:0] corr, output int rounds);
        bit still_active;
        for (int i = 0; i < NUM_VERTICES; i++) begin
            m_root[i] = i;
            m_def[i] = mask[i];
            m_tb[i] = 1'b0;
            m_match[i] = 1'b0;
        end
        for (int j = 0; j < NUM_LINKS; j++) m_growth[j] = 0;
        rounds = 0;
        forever begin
            rounds++;
            plan_growth();
            merge_step();          // first merge cycle still sees the old growth
            m_growth = next_growth;
            merge_step();
            merge_step();
            still_active = any_request();  // checked before the last merge cycle
            merge_step();
            if (!still_active || rounds == MAX_ROUNDS) break;
        end
        for (int j = 0; j < NUM_LINKS; j++) begin
            corr[j] = link_grown(j) && link_bc[j] != int'(BC_ABSENT);
        end
    endtask

    task automatic send(input cmd_word_u c);
        @(posedge clk);
        cmd <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic load_link(input int j, input int w, input int b);
        cmd_word_u c;
        c = '0;
        c.cfg.kind = CMD_LOAD_LINK;
        c.cfg.link = LINK_IDX_WIDTH'(j);
        c.cfg.weight = WEIGHT_WIDTH'(w);
        c.cfg.bc = bc_t'(2'(b));
        send(c);
        repeat (2) @(posedge clk);
        link_w[j] = w;
        link_bc[j] = (b == 3) ? int'(BC_NONE) : b;  // spare code acts as none
    endtask

    task automatic load_chain(input int w, input int end_bc);
        for (int j = 0; j < NUM_LINKS; j++) begin
            load_link(j, w, (j == 0 || j == NUM_LINKS - 1) ? end_bc : int'(BC_NONE));
        end
    endtask

    task automatic load_syndrome(input logic [NUM_VERTICES-1:0] mask);
        cmd_word_u c;
        c = '0;
        c.syn.kind = CMD_SYNDROME;
        c.syn.defect = mask;
        send(c);
        repeat (3) @(posedge clk);
    endtask

    task automatic store_context(input logic [NUM_LINKS-1:0] expected);
        cmd_word_u c;
        c = '0;
        c.cfg.kind = CMD_STORE;
        send(c);
        repeat (6) @(negedge clk);
        assert (correction == expected) else begin
            $display("Mismatch at %0t: correction %b after store, expected %b",
                     $time, correction, expected);
            errors++;
        end
    endtask

    task automatic run_check(input logic [NUM_VERTICES-1:0] mask,
                             output logic [NUM_LINKS-1:0] got);
        cmd_word_u c;
        logic [NUM_LINKS-1:0] expected;
        int exp_rounds;
        int n;
        predict(mask, expected, exp_rounds);
        c = '0;
        c.cfg.kind = CMD_RUN;
        send(c);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done);
        assert (correction == expected) else begin
            $display("Mismatch at %0t: correction %b, expected %b", $time, correction, expected);
            errors++;
        end
        assert (n == (MERGE_CYCLES + 1) * exp_rounds + 4) else begin
            $display("Mismatch at %0t: run took %0d cycles, expected %0d rounds", $time, n,
                     exp_rounds);
            errors++;
        end
        got = correction;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
        test_count++;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            $display("test %0d %s: failed", test_count, test_name);
            failed_tests++;
        end
    endtask

    initial begin
        logic [NUM_LINKS-1:0] got;
        logic [NUM_LINKS-1:0] corr_a;
        logic [NUM_VERTICES-1:0] mask;
        int w;
        reset = 1'b1;
        cmd = '0;
        cmd_valid = 1'b0;
        do_not_store = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        start_test("reset and empty syndrome");
        @(negedge clk);
        assert (!busy && !done && correction == '0) else begin
            $display("Mismatch at %0t: outputs not idle after reset", $time);
            errors++;
        end
        load_syndrome(4'b0000);
        load_chain(2, int'(BC_BOUNDARY));
        run_check(4'b0000, got);
        finish_test();

        start_test("defect pair");
        load_syndrome(4'b0110);
        load_chain(2, int'(BC_BOUNDARY));
        run_check(4'b0110, got);
        finish_test();

        start_test("single defect to boundary");
        load_syndrome(4'b0001);
        load_chain(2, int'(BC_BOUNDARY));
        run_check(4'b0001, got);
        finish_test();

        start_test("absent right boundary");
        load_syndrome(4'b1000);
        load_chain(2, int'(BC_BOUNDARY));
        load_link(NUM_LINKS - 1, 2, int'(BC_ABSENT));
        run_check(4'b1000, got);
        assert (!got[NUM_LINKS-1]) else begin
            $display("Mismatch at %0t: absent link 4 in correction", $time);
            errors++;
        end
        finish_test();

        start_test("context swap");
        load_syndrome(4'b0110);
        load_chain(2, int'(BC_BOUNDARY));
        run_check(4'b0110, corr_a);
        store_context('0);      // second context starts empty
        load_syndrome(4'b0001);
        run_check(4'b0001, got);
        store_context(corr_a);
        @(posedge clk);
        do_not_store <= 1'b1;
        store_context(corr_a);
        @(posedge clk);
        do_not_store <= 1'b0;
        finish_test();

        for (int t = 0; t < NUM_RANDOM; t++) begin
            start_test("random syndrome");
            mask = NUM_VERTICES'(random_bits(NUM_VERTICES));
            load_syndrome(mask);
            for (int j = 0; j < NUM_LINKS; j++) begin
                w = random_bits(WEIGHT_WIDTH);
                load_link(j, (w > MAX_WEIGHT) ? MAX_WEIGHT : w, random_bits(2));
            end
            run_check(mask, got);
            finish_test();
        end

        errors += i_uf_chain_top.i_chk.failures;
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: uf_chain_chk.sv
module uf_chain_chk (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done,
    input logic [uf_pkg::NUM_LINKS-1:0] correction,
    input uf_pkg::bc_t first_bc,
    input uf_pkg::bc_t last_bc
);
    import uf_pkg::*;

    int failures = 0;  // read by the testbench at the end

    done_after_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
        else begin
            $error("done rose without a run in progress");
            failures++;
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    busy_drops_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else begin
            $error("busy still high the cycle after done");
            failures++;
        end

    // absent boundary links never carry a correction
    absent_ends_clear: assert property (@(posedge clk) disable iff (reset)
        !((correction[0] && first_bc == BC_ABSENT)
          || (correction[NUM_LINKS-1] && last_bc == BC_ABSENT)))
        else begin
            $error("correction marks an absent boundary link");
            failures++;
        end

endmodule

bind uf_chain_top uf_chain_chk i_chk (
    .clk(clk),
    .reset(reset),
    .busy(busy),
    .done(done),
    .correction(correction),
    .first_bc(g_link[0].i_link.bc),
    .last_bc(g_link[uf_pkg::NUM_LINKS-1].i_link.bc)
);

// File: uf_chain_top.sv
module uf_chain_top (
    input  logic clk,
    input  logic reset,
    input  uf_pkg::cmd_word_u cmd,
    input  logic cmd_valid,
    input  logic do_not_store,
    output logic [uf_pkg::NUM_LINKS-1:0] correction,
    output logic busy,
    output logic done
);
    import uf_pkg::*;

    stage_t global_stage;
    logic [NUM_LINKS-1:0] link_load;
    logic [WEIGHT_WIDTH-1:0] load_weight;
    bc_t load_bc;
    logic syndrome_load;
    logic [NUM_VERTICES-1:0] defect_mask;
    logic run_start;
    logic [NUM_VERTICES-1:0] grow_req;
    vertex_data_t vertex_data [NUM_VERTICES];
    logic [NUM_LINKS-1:0] link_a_inc;
    logic [NUM_LINKS-1:0] link_b_inc;
    vertex_data_t link_a_in [NUM_LINKS];
    vertex_data_t link_b_in [NUM_LINKS];
    vertex_data_t link_a_out [NUM_LINKS];
    vertex_data_t link_b_out [NUM_LINKS];
    logic [NUM_LINKS-1:0] link_boundary;
    logic [NUM_LINKS-1:0] link_error;

    stage_ctrl i_stage_ctrl (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .grow_req(grow_req),
        .global_stage(global_stage),
        .link_load(link_load),
        .load_weight(load_weight),
        .load_bc(load_bc),
        .syndrome_load(syndrome_load),
        .defect_mask(defect_mask),
        .run_start(run_start)
    );

    for (genvar j = 0; j < NUM_LINKS; j++) begin : g_link
        // vertex j-1 drives the a side; link 0 also takes vertex 0 on a,
        // so both boundary links grow from their a side
        assign link_a_inc[j] = grow_req[(j == 0) ? 0 : j - 1];
        assign link_a_in[j] = vertex_data[(j == 0) ? 0 : j - 1];
        if (j == 0 || j == NUM_LINKS - 1) begin : g_end
            assign link_b_inc[j] = 1'b0;  // open end of the chain
            assign link_b_in[j] = '0;
        end else begin : g_mid
            assign link_b_inc[j] = grow_req[j];
            assign link_b_in[j] = vertex_data[j];
        end

        neighbor_link i_link (
            .clk(clk),
            .reset(reset),
            .global_stage(global_stage),
            .link_load(link_load[j]),
            .weight_in(load_weight),
            .bc_in(load_bc),
            .reset_edge(syndrome_load),
            .do_not_store(do_not_store),
            .a_increase(link_a_inc[j]),
            .b_increase(link_b_inc[j]),
            .a_input_data(link_a_in[j]),
            .b_input_data(link_b_in[j]),
            .a_output_data(link_a_out[j]),
            .b_output_data(link_b_out[j]),
            .fully_grown(),
            .is_boundary(link_boundary[j]),
            .is_error(link_error[j])
        );
    end

    for (genvar i = 0; i < NUM_VERTICES; i++) begin : g_vertex
        vertex_unit i_vertex (
            .clk(clk),
            .reset(reset),
            .global_stage(global_stage),
            .my_id(ADDRESS_WIDTH'(i)),
            .syndrome_load(syndrome_load),
            .defect(defect_mask[i]),
            .left_data((i == 0) ? link_a_out[0] : link_b_out[i]),
            .right_data(link_a_out[i+1]),
            .left_boundary(link_boundary[i]),
            .right_boundary(link_boundary[i+1]),
            .data_out(vertex_data[i]),
            .grow_req(grow_req[i])
        );
    end

    result_collect i_result_collect (
        .clk(clk),
        .reset(reset),
        .global_stage(global_stage),
        .run_start(run_start),
        .link_error(link_error),
        .correction(correction),
        .busy(busy),
        .done(done)
    );

endmodule

// File: uf_pkg.sv
package uf_pkg;

    localparam int NUM_VERTICES = 4;
    localparam int NUM_LINKS = NUM_VERTICES + 1;   // boundary link on each end
    localparam int NUM_CONTEXTS = 2;
    localparam int MAX_WEIGHT = 2;
    localparam int WEIGHT_WIDTH = $clog2(MAX_WEIGHT + 1);
    localparam int ADDRESS_WIDTH = $clog2(NUM_VERTICES);
    localparam int MAX_ROUNDS = 8;
    localparam int MERGE_CYCLES = NUM_VERTICES;    // long enough to cross the chain
    localparam int ROUND_WIDTH = $clog2(MAX_ROUNDS + 1);
    localparam int MERGE_CNT_WIDTH = $clog2(MERGE_CYCLES);
    localparam int CTX_ADDR_WIDTH = $clog2(NUM_CONTEXTS);
    localparam int CTX_WIDTH = WEIGHT_WIDTH + 1;   // growth and is_error
    localparam int CMD_WIDTH = 16;
    localparam int LINK_IDX_WIDTH = 3;

    typedef enum logic [2:0] {
        STAGE_IDLE = 3'd0,
        STAGE_LOAD = 3'd1,
        STAGE_GROW = 3'd2,
        STAGE_MERGE = 3'd3,
        STAGE_RESULT_VALID = 3'd4,
        STAGE_WRITE_TO_MEM = 3'd5
    } stage_t;

    // code 3 is not named, links treat it like BC_NONE
    typedef enum logic [1:0] {
        BC_NONE = 2'd0,
        BC_BOUNDARY = 2'd1,
        BC_ABSENT = 2'd2
    } bc_t;

    typedef enum logic [1:0] {
        CMD_LOAD_LINK = 2'd0,
        CMD_SYNDROME = 2'd1,
        CMD_RUN = 2'd2,
        CMD_STORE = 2'd3
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t kind;
        logic [LINK_IDX_WIDTH-1:0] link;
        logic [WEIGHT_WIDTH-1:0] weight;
        bc_t bc;
        logic [CMD_WIDTH-LINK_IDX_WIDTH-WEIGHT_WIDTH-5:0] spare;
    } cmd_cfg_t;

    typedef struct packed {
        cmd_kind_t kind;
        logic [NUM_VERTICES-1:0] defect;   // bit i is vertex i
        logic [CMD_WIDTH-NUM_VERTICES-3:0] spare;
    } cmd_syn_t;

    // kind sits in the top bits of both views
    typedef union packed {
        cmd_cfg_t cfg;
        cmd_syn_t syn;
    } cmd_word_u;

    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic has_defect;
        logic touches_boundary;
        logic matched;
    } vertex_data_t;

endpackage

// File: vertex_unit.sv
module vertex_unit (
    input  logic clk,
    input  logic reset,
    input  uf_pkg::stage_t global_stage,
    input  logic [uf_pkg::ADDRESS_WIDTH-1:0] my_id,
    input  logic syndrome_load,
    input  logic defect,
    input  uf_pkg::vertex_data_t left_data,
    input  uf_pkg::vertex_data_t right_data,
    input  logic left_boundary,
    input  logic right_boundary,
    output uf_pkg::vertex_data_t data_out,
    output logic grow_req
);
    import uf_pkg::*;

    vertex_data_t cur;
    vertex_data_t nxt;
    vertex_data_t nbr [2];

    assign nbr[0] = left_data;
    assign nbr[1] = right_data;

    // roots only spread out of defect vertices, so one cluster never sees two roots
    // unless it really holds two defects
    always_comb begin
        nxt = cur;
        nxt.touches_boundary = cur.touches_boundary | left_boundary | right_boundary;
        for (int k = 0; k < 2; k++) begin
            nxt.touches_boundary = nxt.touches_boundary | nbr[k].touches_boundary;
            if (nbr[k].has_defect) begin
                if (nbr[k].matched || (cur.has_defect && (nbr[k].root != cur.root))) begin
                    nxt.matched = 1'b1;  // paired with another defect
                end
                if (!nxt.has_defect || (nbr[k].root < nxt.root)) begin
                    nxt.root = nbr[k].root;
                end
                nxt.has_defect = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cur.root <= my_id;
            cur.has_defect <= 1'b0;
            cur.touches_boundary <= 1'b0;
            cur.matched <= 1'b0;
        end else if (syndrome_load) begin
            cur.root <= my_id;
            cur.has_defect <= defect;
            cur.touches_boundary <= 1'b0;
            cur.matched <= 1'b0;
        end else if (global_stage == STAGE_MERGE) begin
            cur <= nxt;
        end
    end

    assign data_out = cur;
    assign grow_req = cur.has_defect && !cur.matched && !cur.touches_boundary;

endmodule
